// File: src.f
+incdir+src
src/uart_pkg.sv
src/byte_fifo.sv
src/uart_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
test/tb_uart.sv

// File: Bender.yml
package:
  name: uart_wb

export_include_dirs:
  - src

sources:
  - src/uart_pkg.sv
  - src/byte_fifo.sv
  - src/uart_regs.sv
  - src/uart_tx.sv
  - src/uart_rx.sv
  - src/uart_top.sv
  - target: test
    files:
      - test/tb_uart.sv

// File: test/tb_uart.sv
////////////////////
// UART testbench with bus tasks, serial models,
// reference functions and a tx frame monitor
////////////////////
`timescale 1ns/10ps
`include "uart_defs.svh"

module tb_uart import uart_pkg::*;
();

    localparam int K_ACK = 0;
    localparam int K_ERR = 1;
    localparam int K_RTY = 2;
    localparam int RSP_LIMIT = 2000;
    localparam int RUN_LIMIT = 400000;

    logic    clk;
    logic    rst;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    tx;
    logic    rx;

    // Model of what the DUT should hold
    logic [31:0]   m_div;
    logic [7:0]    m_stop;
    bus_behavior_t m_bb;
    int            m_tx_count;
    int            frames_sent;
    int            bytes_read;
    int            frames_seen;
    int            cycles;
    integer        seed;
    logic [7:0]    tx_expect [$];
    logic [7:0]    rx_expect [$];

    uart_top DUT (
        .clk    (clk),
        .rst    (rst),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .tx     (tx),
        .rx     (rx)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    ////////////////////
    // Failure reporting
    ////////////////////
    task automatic value_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1, "Run aborted");
    endtask

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles >= RUN_LIMIT)
            abort_run("Simulation ran past its cycle limit");
    end

    ////////////////////
    // Reference model
    ////////////////////
    function automatic int stop_count(input logic [7:0] s);
        return (s == 0) ? 1 : int'(s);
    endfunction

    // Line bits in send order: start, data LSB first, stop bits
    function automatic logic [15:0] expected_frame(input logic [7:0] b, input logic [7:0] s);
        logic [15:0] f;
        f      = '0;
        f[8:1] = b;
        for (int k = 0; k < stop_count(s); k++)
            f[9 + k] = 1'b1;
        return f;
    endfunction

    function automatic logic [31:0] expected_reg(input logic [7:0] adr);
        logic [31:0] w;
        int          rxc;
        w   = '0;
        rxc = frames_sent - bytes_read;
        case (adr)
            `UART_REG_DIVISOR:  w = m_div;
            `UART_REG_CTRL:     w[7:0] = {m_bb, 2'b00, rxc == `UART_FIFO_DEPTH, rxc == 0,
                                          m_tx_count == `UART_FIFO_DEPTH, m_tx_count == 0};
            `UART_REG_RX_COUNT: w = rxc;
            `UART_REG_TX_COUNT: w = m_tx_count;
            `UART_REG_STOP:     w[7:0] = m_stop;
            default:            w = '0;
        endcase
        return w;
    endfunction

    function automatic int expected_kind(input logic we, input logic [7:0] adr);
        logic stuck;
        if (adr != `UART_REG_DATA)
            return K_ACK;
        stuck = we ? (m_tx_count == `UART_FIFO_DEPTH) : (frames_sent == bytes_read);
        if (!stuck)
            return K_ACK;
        case (m_bb)
            bb_error: return K_ERR;
            bb_retry: return K_RTY;
            default:  return K_ACK;
        endcase
    endfunction

    ////////////////////
    // Bus tasks
    ////////////////////
    task automatic bus_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                              output int kind, output logic [31:0] rdat);
        int waited;
        waited = 0;
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = we;
        wb_req.adr = adr;
        wb_req.dat = wdat;
        do
        begin
            @(negedge clk);
            waited++;
            if (waited > RSP_LIMIT)
                abort_run($sformatf("No bus response to address %02h after %0d cycles",
                                    adr, RSP_LIMIT));
        end
        while (!(wb_rsp.ack || wb_rsp.err || wb_rsp.rty));
        assert ((int'(wb_rsp.ack) + int'(wb_rsp.err) + int'(wb_rsp.rty)) == 1)
        else
            value_error($sformatf("more than one response bit at address %02h", adr));
        kind   = wb_rsp.err ? K_ERR : (wb_rsp.rty ? K_RTY : K_ACK);
        rdat   = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic reg_write(input logic [7:0] adr, input logic [31:0] dat);
        int          kind;
        int          want;
        logic [31:0] rdat;
        logic        full;
        want = expected_kind(1'b1, adr);
        full = (m_tx_count == `UART_FIFO_DEPTH);
        bus_access(1'b1, adr, dat, kind, rdat);
        assert (kind == want)
        else
            value_error($sformatf("write to %02h gave kind %0d, expected %0d", adr, kind, want));
        case (adr)
            `UART_REG_DIVISOR: m_div = dat;
            `UART_REG_CTRL:    m_bb = bus_behavior_t'(dat[7:6]);
            `UART_REG_STOP:    m_stop = dat[7:0];
            `UART_REG_DATA:
            begin
                // A full FIFO drops the byte
                if (!full)
                begin
                    m_tx_count++;
                    tx_expect.push_back(dat[7:0]);
                end
            end
            default: ;
        endcase
    endtask

    task automatic reg_read(input logic [7:0] adr);
        int          kind;
        int          want_kind;
        logic [31:0] rdat;
        logic [31:0] want;
        want_kind = expected_kind(1'b0, adr);
        if (adr != `UART_REG_DATA)
            want = expected_reg(adr);
        else if (frames_sent == bytes_read)
            want = '0;
        else
        begin
            want = rx_expect.pop_front();
            bytes_read++;
        end
        bus_access(1'b0, adr, '0, kind, rdat);
        assert (kind == want_kind)
        else
            value_error($sformatf("read of %02h gave kind %0d, expected %0d",
                                  adr, kind, want_kind));
        if (kind == K_ACK)
        begin
            assert (rdat == want)
            else
                value_error($sformatf("read of %02h returned %08h, expected %08h",
                                      adr, rdat, want));
        end
    endtask

    ////////////////////
    // Serial models
    ////////////////////
    task automatic send_frame(input logic [7:0] b, input int div, input logic [7:0] s);
        logic [15:0] f;
        int          nbits;
        f     = expected_frame(b, s);
        nbits = 9 + stop_count(s);
        for (int i = 0; i < nbits; i++)
        begin
            @(negedge clk);
            rx = f[i];
            repeat (div) @(negedge clk);
        end
        // Short gap so the receiver is idle again
        repeat (5) @(negedge clk);
        rx_expect.push_back(b);
        frames_sent++;
    endtask

    always
    begin : tx_monitor
        logic [15:0] f;
        logic [7:0]  b;
        int          nbits;
        @(negedge clk);
        if (!rst && tx === 1'b0)
        begin
            if (tx_expect.size() == 0)
                abort_run("A frame appeared on tx with no byte written");
            b     = tx_expect.pop_front();
            f     = expected_frame(b, m_stop);
            nbits = 9 + stop_count(m_stop);
            // Middle of the start bit, then one bit time per step
            repeat (m_div / 2) @(negedge clk);
            for (int i = 0; i < nbits; i++)
            begin
                if (i > 0)
                    repeat (m_div + 1) @(negedge clk);
                assert (tx === f[i])
                else
                    value_error($sformatf("tx bit %0d of byte %02h is %b, expected %b",
                                          i, b, tx, f[i]));
            end
            frames_seen++;
        end
    end

    task automatic wait_frames(input int target);
        int limit;
        int waited;
        limit  = (target - frames_seen) * 12 * (m_div + 1) + 200;
        waited = 0;
        while (frames_seen < target)
        begin
            @(negedge clk);
            waited++;
            if (waited > limit)
                abort_run("Transmitter did not send the written bytes in time");
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////
    initial
    begin : stimulus
        logic [7:0]  b;
        logic [7:0]  want;
        logic [31:0] rdat;
        int          kind;
        time         t_frame;
        time         t_rsp;
        seed        = 32'h5184;
        cycles      = 0;
        wb_req      = '0;
        rx          = 1'b1;
        rst         = 1'b1;
        m_div       = '0;
        m_stop      = `UART_STOP_RESET;
        m_bb        = bb_lock;
        m_tx_count  = 0;
        frames_sent = 0;
        bytes_read  = 0;
        frames_seen = 0;
        repeat (16) @(negedge clk);
        rst = 1'b0;

        // Reset values
        assert (tx === 1'b1)
        else
            value_error("tx is not high after reset");
        reg_read(`UART_REG_DIVISOR);
        reg_read(`UART_REG_CTRL);
        reg_read(`UART_REG_STOP);
        reg_read(`UART_REG_RX_COUNT);
        reg_read(`UART_REG_TX_COUNT);

        // Register access
        reg_write(`UART_REG_DIVISOR, 32'h1234_5678);
        reg_read(`UART_REG_DIVISOR);
        reg_write(`UART_REG_STOP, 32'h3);
        reg_read(`UART_REG_STOP);
        reg_write(`UART_REG_CTRL, {24'h0, bb_retry, 6'h0});
        reg_read(`UART_REG_CTRL);
        reg_write(`UART_REG_RX_COUNT, 32'h5);
        reg_write(`UART_REG_TX_COUNT, 32'h7);
        reg_write(8'h14, 32'hdead_beef);
        reg_read(`UART_REG_RX_COUNT);
        reg_read(`UART_REG_TX_COUNT);
        reg_read(8'h14);
        reg_read(8'h1C);
        reg_read(`UART_REG_DIVISOR);
        reg_read(`UART_REG_STOP);
        reg_read(`UART_REG_CTRL);
        reg_write(`UART_REG_CTRL, {24'h0, bb_lock, 6'h0});

        // Transmit with one, then two stop bits
        reg_write(`UART_REG_DIVISOR, 32'd99);
        for (int s = 1; s <= 2; s++)
        begin
            reg_write(`UART_REG_STOP, s);
            repeat (4) reg_write(`UART_REG_DATA, {24'h0, 8'($random(seed))});
            wait_frames(frames_seen + 4);
            m_tx_count = 0;
            repeat (2 * (m_div + 1)) @(negedge clk);
            reg_read(`UART_REG_TX_COUNT);
        end
        reg_read(`UART_REG_CTRL);

        // Receive
        reg_write(`UART_REG_STOP, 32'h1);
        repeat (3) send_frame(8'($random(seed)), m_div, m_stop);
        reg_read(`UART_REG_RX_COUNT);
        reg_read(`UART_REG_DATA);
        reg_read(`UART_REG_RX_COUNT);
        repeat (2) send_frame(8'($random(seed)), m_div, m_stop);
        reg_read(`UART_REG_RX_COUNT);
        repeat (4)
        begin
            reg_read(`UART_REG_DATA);
            reg_read(`UART_REG_RX_COUNT);
        end

        // Reads of an empty RX FIFO
        reg_write(`UART_REG_CTRL, {24'h0, bb_error, 6'h0});
        reg_read(`UART_REG_DATA);
        reg_write(`UART_REG_CTRL, {24'h0, bb_retry, 6'h0});
        reg_read(`UART_REG_DATA);
        reg_write(`UART_REG_CTRL, {24'h0, bb_ack, 6'h0});
        reg_read(`UART_REG_DATA);
        reg_read(`UART_REG_CTRL);
        reg_write(`UART_REG_CTRL, {24'h0, bb_lock, 6'h0});
        b = 8'($random(seed));
        t_frame = $time;
        fork
            begin
                bus_access(1'b0, `UART_REG_DATA, '0, kind, rdat);
                t_rsp = $time;
            end
            send_frame(b, m_div, m_stop);
        join
        want = rx_expect.pop_front();
        bytes_read++;
        assert (kind == K_ACK && rdat == {24'h0, want})
        else
            value_error($sformatf("lock read gave kind %0d data %08h, expected byte %02h",
                                  kind, rdat, want));
        assert (t_rsp > t_frame + 9 * (m_div + 1) * 40)
        else
            value_error("lock read completed before the frame arrived");

        // Writes to a full TX FIFO
        reg_write(`UART_REG_DIVISOR, 32'd9999);
        reg_write(`UART_REG_CTRL, {24'h0, bb_error, 6'h0});
        reg_write(`UART_REG_DATA, {24'h0, 8'($random(seed))});
        // First byte goes straight into the transmitter
        m_tx_count--;
        repeat (9) reg_write(`UART_REG_DATA, {24'h0, 8'($random(seed))});
        reg_read(`UART_REG_CTRL);
        reg_read(`UART_REG_TX_COUNT);
        reg_write(`UART_REG_CTRL, {24'h0, bb_ack, 6'h0});
        reg_write(`UART_REG_DATA, {24'h0, 8'($random(seed))});
        reg_read(`UART_REG_TX_COUNT);

        $display("Test passed");
        $finish;
    end

endmodule

// File: src/uart_top.sv
////////////////////
// UART top level with register block, FIFOs and serial engines
////////////////////
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_top import uart_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp,
    output logic    tx,
    input  logic    rx
);

    line_cfg_t               line_cfg;
    fifo_status_t            tx_status;
    fifo_status_t            rx_status;
    logic                    tx_push;
    logic [`UART_DATA_W-1:0] tx_byte;
    logic                    tx_pop;
    logic [`UART_DATA_W-1:0] tx_head;
    logic                    rx_push;
    logic [`UART_DATA_W-1:0] rx_byte;
    logic                    rx_pop;
    logic [`UART_DATA_W-1:0] rx_head;

    uart_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .tx_status (tx_status),
        .rx_status (rx_status),
        .rx_byte   (rx_head),
        .tx_push   (tx_push),
        .tx_byte   (tx_byte),
        .rx_pop    (rx_pop),
        .line_cfg  (line_cfg)
    );

    ////////////////////
    // Transmit path
    ////////////////////
    byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) tx_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (tx_push),
        .wr_data (tx_byte),
        .pop     (tx_pop),
        .rd_data (tx_head),
        .status  (tx_status)
    );

    uart_tx u_tx (
        .clk         (clk),
        .rst         (rst),
        .line_cfg    (line_cfg),
        .fifo_status (tx_status),
        .fifo_byte   (tx_head),
        .pop         (tx_pop),
        .tx          (tx)
    );

    ////////////////////
    // Receive path
    ////////////////////
    byte_fifo #(.DEPTH(`UART_FIFO_DEPTH)) rx_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (rx_push),
        .wr_data (rx_byte),
        .pop     (rx_pop),
        .rd_data (rx_head),
        .status  (rx_status)
    );

    uart_rx u_rx (
        .clk      (clk),
        .rst      (rst),
        .line_cfg (line_cfg),
        .rx       (rx),
        .push     (rx_push),
        .rx_byte  (rx_byte)
    );

endmodule

// File: src/uart_rx.sv
////////////////////
// Serial receiver
////////////////////
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_rx import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  line_cfg_t               line_cfg,
    input  logic                    rx,
    output logic                    push,
    output logic [`UART_DATA_W-1:0] rx_byte
);

    serial_state_t          state;
    logic [`UART_BUS_W-1:0] cnt;
    logic [7:0]             bit_idx;
    logic [7:0]             last_stop;
    logic                   bit_done;
    logic                   sample;

    assign last_stop = (line_cfg.stop_bits == '0) ? 8'd0 : line_cfg.stop_bits - 8'd1;
    assign bit_done  = (cnt >= line_cfg.divisor);
    // Middle of each data bit
    assign sample    = (state == st_data) && (cnt == (line_cfg.divisor >> 1));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            push    <= 1'b0;
        end
        else
        begin
            push <= 1'b0;
            case (state)
                st_idle:
                begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!rx)
                        state <= st_start;
                end
                st_start:
                begin
                    // Sit out the start bit
                    if (bit_done)
                    begin
                        cnt   <= '0;
                        state <= st_data;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                st_data:
                begin
                    if (bit_done)
                    begin
                        cnt <= '0;
                        if (bit_idx == `UART_DATA_W - 1)
                        begin
                            bit_idx <= '0;
                            state   <= st_stop;
                        end
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                begin
                    // Stop bits counted, not checked
                    if (bit_done)
                    begin
                        cnt <= '0;
                        if (bit_idx == last_stop)
                        begin
                            push  <= 1'b1;
                            state <= st_idle;
                        end
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
            endcase
        end
    end

    // LSB arrives first, so shift in from the top
    always_ff @(posedge clk)
    begin
        if (sample)
            rx_byte <= {rx, rx_byte[`UART_DATA_W-1:1]};
    end

endmodule

// File: src/uart_tx.sv
////////////////////
// Serial transmitter
////////////////////
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_tx import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  line_cfg_t               line_cfg,
    input  fifo_status_t            fifo_status,
    input  logic [`UART_DATA_W-1:0] fifo_byte,
    output logic                    pop,
    output logic                    tx
);

    serial_state_t           state;
    logic [`UART_BUS_W-1:0]  cnt;
    logic [7:0]              bit_idx;
    logic [`UART_DATA_W-1:0] shreg;
    logic [7:0]              last_stop;
    logic                    bit_done;

    // Zero stop bits still sends one
    assign last_stop = (line_cfg.stop_bits == '0) ? 8'd0 : line_cfg.stop_bits - 8'd1;
    assign bit_done  = (cnt >= line_cfg.divisor);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state   <= st_idle;
            cnt     <= '0;
            bit_idx <= '0;
            pop     <= 1'b0;
            tx      <= 1'b1;
        end
        else
        begin
            pop <= 1'b0;
            case (state)
                st_idle:
                begin
                    cnt     <= '0;
                    bit_idx <= '0;
                    if (!fifo_status.empty)
                    begin
                        pop   <= 1'b1;
                        state <= st_start;
                    end
                end
                st_start:
                begin
                    // Line drops once the pop cycle is over
                    if (pop)
                        tx <= 1'b0;
                    else if (bit_done)
                    begin
                        cnt   <= '0;
                        tx    <= shreg[0];
                        state <= st_data;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                st_data:
                begin
                    if (bit_done)
                    begin
                        cnt <= '0;
                        if (bit_idx == `UART_DATA_W - 1)
                        begin
                            bit_idx <= '0;
                            tx      <= 1'b1;
                            state   <= st_stop;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shreg[1];
                        end
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                begin
                    if (bit_done)
                    begin
                        cnt <= '0;
                        if (bit_idx == last_stop)
                            state <= st_idle;
                        else
                            bit_idx <= bit_idx + 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
            endcase
        end
    end

    // Head byte loaded while idle, LSB first out
    always_ff @(posedge clk)
    begin
        if (state == st_idle)
            shreg <= fifo_byte;
        else if (state == st_data && bit_done)
            shreg <= shreg >> 1;
    end

endmodule

// File: src/uart_regs.sv
////////////////////
// Bus slave with address decode, configuration registers
// and the full/empty bus behavior of data accesses
////////////////////
`timescale 1ns/10ps
`include "uart_defs.svh"

module uart_regs import uart_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  wb_req_t                 wb_req,
    output wb_rsp_t                 wb_rsp,
    input  fifo_status_t            tx_status,
    input  fifo_status_t            rx_status,
    input  logic [`UART_DATA_W-1:0] rx_byte,
    output logic                    tx_push,
    output logic [`UART_DATA_W-1:0] tx_byte,
    output logic                    rx_pop,
    output line_cfg_t               line_cfg
);

    typedef enum logic {
        bus_idle,
        bus_resp
    } bus_state_t;

    bus_state_t    state;
    bus_behavior_t bb;
    ctrl_reg_t     ctrl_rd;
    wb_rsp_t       rsp_nxt;
    logic          data_sel;
    logic          busy;
    logic          blocked;
    logic          accept;
    logic          push_nxt;
    logic          pop_nxt;

    // Control read view, bb plus live FIFO flags
    assign ctrl_rd.bb   = bb;
    assign ctrl_rd.rsvd = {2'b00, rx_status.full, rx_status.empty,
                           tx_status.full, tx_status.empty};

    assign data_sel = (wb_req.adr == `UART_REG_DATA);
    // Writes need TX room, reads need an RX byte
    assign busy     = wb_req.we ? tx_status.full : rx_status.empty;
    assign blocked  = data_sel && busy && (bb == bb_lock);
    assign accept   = (state == bus_idle) && wb_req.cyc && wb_req.stb && !blocked;

    ////////////////////
    // Response decode
    ////////////////////
    always_comb
    begin
        rsp_nxt     = '0;
        rsp_nxt.ack = 1'b1;
        push_nxt    = 1'b0;
        pop_nxt     = 1'b0;
        if (data_sel)
        begin
            if (busy)
            begin
                // Ack mode keeps the plain ack, drops the byte or reads zero
                if (bb == bb_error)
                begin
                    rsp_nxt.ack = 1'b0;
                    rsp_nxt.err = 1'b1;
                end
                else if (bb == bb_retry)
                begin
                    rsp_nxt.ack = 1'b0;
                    rsp_nxt.rty = 1'b1;
                end
            end
            else if (wb_req.we)
                push_nxt = 1'b1;
            else
            begin
                pop_nxt = 1'b1;
                rsp_nxt.dat[`UART_DATA_W-1:0] = rx_byte;
            end
        end
        else if (!wb_req.we)
        begin
            case (wb_req.adr)
                `UART_REG_DIVISOR:  rsp_nxt.dat = line_cfg.divisor;
                `UART_REG_CTRL:     rsp_nxt.dat[7:0] = ctrl_rd;
                `UART_REG_RX_COUNT: rsp_nxt.dat[CNT_W-1:0] = rx_status.count;
                `UART_REG_TX_COUNT: rsp_nxt.dat[CNT_W-1:0] = tx_status.count;
                `UART_REG_STOP:     rsp_nxt.dat[7:0] = line_cfg.stop_bits;
                default:            rsp_nxt.dat = '0;
            endcase
        end
    end

    ////////////////////
    // Bus FSM and registers
    ////////////////////
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state              <= bus_idle;
            wb_rsp             <= '0;
            tx_push            <= 1'b0;
            rx_pop             <= 1'b0;
            bb                 <= bb_lock;
            line_cfg.divisor   <= '0;
            line_cfg.stop_bits <= `UART_STOP_RESET;
        end
        else if (state == bus_resp)
        begin
            // One response cycle, then back to idle
            state   <= bus_idle;
            wb_rsp  <= '0;
            tx_push <= 1'b0;
            rx_pop  <= 1'b0;
        end
        else if (accept)
        begin
            state   <= bus_resp;
            wb_rsp  <= rsp_nxt;
            tx_push <= push_nxt;
            rx_pop  <= pop_nxt;
            if (wb_req.we)
            begin
                case (wb_req.adr)
                    `UART_REG_DIVISOR: line_cfg.divisor <= wb_req.dat;
                    `UART_REG_CTRL:    bb <= bus_behavior_t'(wb_req.dat[7:6]);
                    `UART_REG_STOP:    line_cfg.stop_bits <= wb_req.dat[7:0];
                    default:           ;
                endcase
            end
        end
    end

    // Byte to send, pushed during the response cycle
    always_ff @(posedge clk)
    begin
        if (accept)
            tx_byte <= wb_req.dat[`UART_DATA_W-1:0];
    end

endmodule

// File: src/byte_fifo.sv
////////////////////
// Byte FIFO with fill count and status flags
////////////////////
`timescale 1ns/10ps
`include "uart_defs.svh"

module byte_fifo import uart_pkg::*;
#(
    parameter int DEPTH = `UART_FIFO_DEPTH
)
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    push,
    input  logic [`UART_DATA_W-1:0] wr_data,
    input  logic                    pop,
    output logic [`UART_DATA_W-1:0] rd_data,
    output fifo_status_t            status
);

    localparam int AW = $clog2(DEPTH);

    logic [`UART_DATA_W-1:0] mem [DEPTH];
    logic [AW-1:0]           wr_ptr;
    logic [AW-1:0]           rd_ptr;
    logic [AW:0]             count;
    logic                    empty;
    logic                    full;
    logic                    do_push;
    logic                    do_pop;

    assign empty   = (count == '0);
    // Top bit alone means count equals DEPTH
    assign full    = count[AW];
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (do_push)
            mem[wr_ptr] <= wr_data;
    end

    // Oldest entry always on the output
    assign rd_data      = mem[rd_ptr];
    assign status.empty = empty;
    assign status.full  = full;
    assign status.count = count;

endmodule

// File: src/uart_pkg.sv
////////////////////
// Bus, FIFO status, line configuration and control types
////////////////////
`include "uart_defs.svh"

package uart_pkg;

    localparam int CNT_W = $clog2(`UART_FIFO_DEPTH) + 1;

    // What a data access does when its FIFO is full or empty
    typedef enum logic [1:0] {
        bb_lock  = 2'd0,
        bb_error = 2'd1,
        bb_retry = 2'd2,
        bb_ack   = 2'd3
    } bus_behavior_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`UART_ADDR_W-1:0] adr;
        logic [`UART_BUS_W-1:0]  dat;
    } wb_req_t;

    typedef struct packed {
        logic                   ack;
        logic                   err;
        logic                   rty;
        logic [`UART_BUS_W-1:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic             empty;
        logic             full;
        logic [CNT_W-1:0] count;
    } fifo_status_t;

    typedef struct packed {
        logic [`UART_BUS_W-1:0] divisor;
        logic [7:0]             stop_bits;
    } line_cfg_t;

    typedef struct packed {
        bus_behavior_t bb;
        logic [5:0]    rsvd;
    } ctrl_reg_t;

    // Frame position, common to both serial directions
    typedef enum logic [1:0] {
        st_idle,
        st_start,
        st_data,
        st_stop
    } serial_state_t;

endpackage

// File: src/uart_defs.svh
////////////////////
// Widths, FIFO depth, register offsets and reset values
////////////////////
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

`define UART_DATA_W      8
`define UART_BUS_W       32
`define UART_ADDR_W      8
`define UART_FIFO_DEPTH  8

// Register map, low address byte
`define UART_REG_DATA     8'h00
`define UART_REG_DIVISOR  8'h04
`define UART_REG_CTRL     8'h08
`define UART_REG_RX_COUNT 8'h0C
`define UART_REG_TX_COUNT 8'h10
`define UART_REG_STOP     8'h18

`define UART_STOP_RESET  8'd1

`endif
